/* design/fc_geometry_pkg.sv */
// Layer shape constants for the output layer, referenced by scoped name from RTL and testbench.
package fc_geometry_pkg;

   // Features per sample.
   localparam int INPUT_NUM = 16;

   // Neurons in the layer, one per class.
   localparam int OUTPUT_NUM = 10;

   // The dot product is split into groups of four products.
   localparam int GROUP_SIZE = 4;
   localparam int GROUP_NUM = INPUT_NUM / GROUP_SIZE;

   // Weight words are stored neuron-major: neuron n, feature f at n * INPUT_NUM + f.
   localparam int WEIGHT_NUM = INPUT_NUM * OUTPUT_NUM;

   // Weights come first in the load stream, then one bias per neuron.
   localparam int PARAM_NUM = WEIGHT_NUM + OUTPUT_NUM;

   // Wide enough to count every loaded word.
   localparam int PARAM_CNT_W = 8;

endpackage

/* design/fc_arith_pkg.sv */
// Number widths, class code values and latency of the decision path, shared by RTL and testbench.
package fc_arith_pkg;

   // Signed feature width.
   localparam int DATA_W = 16;

   // Signed width of weight and bias words.
   localparam int WEIGHT_W = 8;

   // Sixteen products of 24 bits need four more bits, the bias one more.
   localparam int ACC_W = DATA_W + WEIGHT_W + 5;

   // Neuron index carried through the compare tree.
   localparam int INDEX_W = 4;

   // Class code on the output.
   localparam int CLASS_W = 4;

   // Class 0 is shown as 10 so that a zero code never looks like a result.
   localparam logic [CLASS_W-1:0] ZERO_CLASS_CODE = 4'd10;

   // Three sum stages plus four decision stages.
   localparam int DEC_LATENCY = 7;

endpackage

/* design/fc_param_store.sv */
// Parameter store that takes weights then biases from the serial strobe stream and holds them.
`timescale 1ns/1ps

module fc_param_store (
   input  logic                                    i_clk,
   input  logic                                    i_rst,
   input  logic                                    i_weight_valid,
   input  logic [fc_arith_pkg::WEIGHT_W-1:0]       i_filter,
   output logic                                    o_load_done,
   output logic [fc_geometry_pkg::WEIGHT_NUM-1:0]
                [fc_arith_pkg::WEIGHT_W-1:0]       o_weights,
   output logic [fc_geometry_pkg::OUTPUT_NUM-1:0]
                [fc_arith_pkg::WEIGHT_W-1:0]       o_biases
);

   logic [fc_geometry_pkg::PARAM_CNT_W-1:0] param_cnt;
   logic                                    load_en;
   logic                                    is_bias;
   logic                                    last_word;
   logic [fc_arith_pkg::INDEX_W-1:0]        bias_idx;

   assign load_en   = i_weight_valid && !o_load_done; // Words after the last one are dropped.
   assign is_bias   = (param_cnt >= fc_geometry_pkg::PARAM_CNT_W'(fc_geometry_pkg::WEIGHT_NUM));
   assign last_word = (param_cnt == fc_geometry_pkg::PARAM_CNT_W'(fc_geometry_pkg::PARAM_NUM - 1));

   // The bias slot for the current word is only meaningful once the weights are in.
   assign bias_idx = fc_arith_pkg::INDEX_W'(param_cnt
                     - fc_geometry_pkg::PARAM_CNT_W'(fc_geometry_pkg::WEIGHT_NUM));

   always_ff @(posedge i_clk) begin
      if (!i_rst) begin
         param_cnt   <= '0;
         o_load_done <= 1'b0;
      end else if (load_en) begin
         param_cnt <= param_cnt + 1'b1;
         if (last_word) begin
            o_load_done <= 1'b1; // Stays set until the next reset.
         end
      end
   end

   // Cleared at reset so that a sample sent before loading sees zero parameters.
   always_ff @(posedge i_clk) begin
      if (!i_rst) begin
         o_weights <= '0;
         o_biases  <= '0;
      end else if (load_en) begin
         if (is_bias) begin
            o_biases[bias_idx] <= i_filter;
         end else begin
            o_weights[param_cnt] <= i_filter;
         end
      end
   end

endmodule

/* design/fc_dot_product.sv */
// Three-stage pipelined sum of products plus bias for all ten neurons of the layer.
`timescale 1ns/1ps

module fc_dot_product (
   input  logic                                    i_clk,
   input  logic                                    i_rst,
   input  logic                                    i_valid,
   input  logic [fc_geometry_pkg::INPUT_NUM-1:0]
                [fc_arith_pkg::DATA_W-1:0]         i_data,
   input  logic [fc_geometry_pkg::WEIGHT_NUM-1:0]
                [fc_arith_pkg::WEIGHT_W-1:0]       i_weights,
   input  logic [fc_geometry_pkg::OUTPUT_NUM-1:0]
                [fc_arith_pkg::WEIGHT_W-1:0]       i_biases,
   output logic                                    o_sum_valid,
   output logic [fc_geometry_pkg::OUTPUT_NUM-1:0]
                [fc_arith_pkg::ACC_W-1:0]          o_sums
);

   logic signed [fc_arith_pkg::ACC_W-1:0] group_next
      [fc_geometry_pkg::OUTPUT_NUM][fc_geometry_pkg::GROUP_NUM];
   logic signed [fc_arith_pkg::ACC_W-1:0] group_sum
      [fc_geometry_pkg::OUTPUT_NUM][fc_geometry_pkg::GROUP_NUM];
   logic signed [fc_arith_pkg::ACC_W-1:0] pair_sum
      [fc_geometry_pkg::OUTPUT_NUM][2];
   logic                                  group_valid;
   logic                                  pair_valid;

   // Four products per group, all operands signed and extended to the full sum width.
   always_comb begin
      for (int n = 0; n < fc_geometry_pkg::OUTPUT_NUM; n++) begin
         for (int g = 0; g < fc_geometry_pkg::GROUP_NUM; g++) begin
            group_next[n][g] = '0;
            for (int k = 0; k < fc_geometry_pkg::GROUP_SIZE; k++) begin
               group_next[n][g] = group_next[n][g]
                  + $signed(i_data[g * fc_geometry_pkg::GROUP_SIZE + k])
                  * $signed(i_weights[n * fc_geometry_pkg::INPUT_NUM
                                      + g * fc_geometry_pkg::GROUP_SIZE + k]);
            end
         end
         group_next[n][fc_geometry_pkg::GROUP_NUM-1] =
            group_next[n][fc_geometry_pkg::GROUP_NUM-1] + $signed(i_biases[n]); // Bias rides here.
      end
   end

   // Valid bits follow the data, so each stage can hold a different sample.
   always_ff @(posedge i_clk) begin
      if (!i_rst) begin
         group_valid <= 1'b0;
         pair_valid  <= 1'b0;
         o_sum_valid <= 1'b0;
      end else begin
         group_valid <= i_valid;
         pair_valid  <= group_valid;
         o_sum_valid <= pair_valid;
      end
   end

   always_ff @(posedge i_clk) begin
      if (i_valid) begin
         group_sum <= group_next;
      end
   end

   // Groups 0 and 1 form the low half, groups 2 and 3 the high half.
   always_ff @(posedge i_clk) begin
      if (group_valid) begin
         for (int n = 0; n < fc_geometry_pkg::OUTPUT_NUM; n++) begin
            pair_sum[n][0] <= group_sum[n][0] + group_sum[n][1];
            pair_sum[n][1] <= group_sum[n][2] + group_sum[n][3];
         end
      end
   end

   always_ff @(posedge i_clk) begin
      if (pair_valid) begin
         for (int n = 0; n < fc_geometry_pkg::OUTPUT_NUM; n++) begin
            o_sums[n] <= pair_sum[n][0] + pair_sum[n][1];
         end
      end
   end

endmodule

/* design/fc_argmax.sv */
// Pipelined compare tree that finds the largest neuron sum and encodes its class code.
`timescale 1ns/1ps

module fc_argmax (
   input  logic                                    i_clk,
   input  logic                                    i_rst,
   input  logic                                    i_valid,
   input  logic [fc_geometry_pkg::OUTPUT_NUM-1:0]
                [fc_arith_pkg::ACC_W-1:0]          i_sums,
   output logic                                    o_dec_done,
   output logic [fc_arith_pkg::CLASS_W-1:0]        o_class
);

   logic signed [fc_arith_pkg::ACC_W-1:0] s1_val [5];
   logic        [fc_arith_pkg::INDEX_W-1:0] s1_idx [5];
   logic                                  s1_valid;
   logic signed [fc_arith_pkg::ACC_W-1:0] s2_val [3];
   logic        [fc_arith_pkg::INDEX_W-1:0] s2_idx [3];
   logic                                  s2_valid;
   logic signed [fc_arith_pkg::ACC_W-1:0] c3_val;
   logic        [fc_arith_pkg::INDEX_W-1:0] c3_idx;
   logic        [fc_arith_pkg::INDEX_W-1:0] s3_idx;
   logic                                  s3_valid;

   always_ff @(posedge i_clk) begin
      if (!i_rst) begin
         s1_valid   <= 1'b0;
         s2_valid   <= 1'b0;
         s3_valid   <= 1'b0;
         o_dec_done <= 1'b0;
      end else begin
         s1_valid   <= i_valid;
         s2_valid   <= s1_valid;
         s3_valid   <= s2_valid;
         o_dec_done <= s3_valid;
      end
   end

   // Ten to five. The right neuron must be strictly greater to win.
   always_ff @(posedge i_clk) begin
      if (i_valid) begin
         for (int p = 0; p < 5; p++) begin
            if ($signed(i_sums[2 * p + 1]) > $signed(i_sums[2 * p])) begin
               s1_val[p] <= $signed(i_sums[2 * p + 1]);
               s1_idx[p] <= fc_arith_pkg::INDEX_W'(2 * p + 1);
            end else begin
               s1_val[p] <= $signed(i_sums[2 * p]);
               s1_idx[p] <= fc_arith_pkg::INDEX_W'(2 * p);
            end
         end
      end
   end

   // Five to three. The last candidate passes straight through.
   always_ff @(posedge i_clk) begin
      if (s1_valid) begin
         for (int p = 0; p < 2; p++) begin
            if (s1_val[2 * p + 1] > s1_val[2 * p]) begin
               s2_val[p] <= s1_val[2 * p + 1];
               s2_idx[p] <= s1_idx[2 * p + 1];
            end else begin
               s2_val[p] <= s1_val[2 * p];
               s2_idx[p] <= s1_idx[2 * p];
            end
         end
         s2_val[2] <= s1_val[4];
         s2_idx[2] <= s1_idx[4];
      end
   end

   // Candidates are in rising index order, so keeping the incumbent on a tie favours the lower.
   always_comb begin
      c3_val = s2_val[0];
      c3_idx = s2_idx[0];
      if (s2_val[1] > c3_val) begin
         c3_val = s2_val[1];
         c3_idx = s2_idx[1];
      end
      if (s2_val[2] > c3_val) begin
         c3_val = s2_val[2];
         c3_idx = s2_idx[2];
      end
   end

   always_ff @(posedge i_clk) begin
      if (s2_valid) begin
         s3_idx <= c3_idx;
      end
   end

   always_ff @(posedge i_clk) begin
      if (!i_rst) begin
         o_class <= '0;
      end else if (s3_valid) begin
         o_class <= (s3_idx == '0) ? fc_arith_pkg::ZERO_CLASS_CODE
                                   : fc_arith_pkg::CLASS_W'(s3_idx); // Held until the next result.
      end
   end

endmodule

/* design/fc_decision_top.sv */
// Top level of the classifier output layer: parameter store, dot products and argmax decision.
`timescale 1ns/1ps

module fc_decision_top (
   input  logic                                    i_clk,
   input  logic                                    i_rst,
   input  logic                                    i_valid,
   input  logic [fc_geometry_pkg::INPUT_NUM-1:0]
                [fc_arith_pkg::DATA_W-1:0]         i_data,
   input  logic                                    i_weight_valid,
   input  logic [fc_arith_pkg::WEIGHT_W-1:0]       i_filter,
   output logic                                    o_load_done,
   output logic                                    o_dec_done,
   output logic [fc_arith_pkg::CLASS_W-1:0]        o_class
);

   logic [fc_geometry_pkg::WEIGHT_NUM-1:0][fc_arith_pkg::WEIGHT_W-1:0] weights;
   logic [fc_geometry_pkg::OUTPUT_NUM-1:0][fc_arith_pkg::WEIGHT_W-1:0] biases;
   logic [fc_geometry_pkg::OUTPUT_NUM-1:0][fc_arith_pkg::ACC_W-1:0]    sums;
   logic                                                               sum_valid;

   fc_param_store u_param_store (
      .i_clk          (i_clk),
      .i_rst          (i_rst),
      .i_weight_valid (i_weight_valid),
      .i_filter       (i_filter),
      .o_load_done    (o_load_done),
      .o_weights      (weights),
      .o_biases       (biases)
   );

   // Samples are taken whether or not loading has finished.
   fc_dot_product u_dot_product (
      .i_clk       (i_clk),
      .i_rst       (i_rst),
      .i_valid     (i_valid),
      .i_data      (i_data),
      .i_weights   (weights),
      .i_biases    (biases),
      .o_sum_valid (sum_valid),
      .o_sums      (sums)
   );

   fc_argmax u_argmax (
      .i_clk      (i_clk),
      .i_rst      (i_rst),
      .i_valid    (sum_valid),
      .i_sums     (sums),
      .o_dec_done (o_dec_done),
      .o_class    (o_class)
   );

endmodule

/* verification/tb_clock_gen.sv */
// Testbench clock and active-low reset source; a rising i_rst_req starts another 5-cycle reset.
`timescale 1ns/1ps

module tb_clock_gen (
   input  logic i_rst_req,
   output logic o_clk,
   output logic o_rst
);

   localparam int HALF_PERIOD = 2; // 4 ns clock.
   localparam int RESET_CYCLES = 5;

   initial begin
      o_clk = 1'b0;
      forever #HALF_PERIOD o_clk = ~o_clk;
   end

   // Reset changes 1 ns after the edge, like every other stimulus.
   initial begin
      o_rst = 1'b0;
      forever begin
         repeat (RESET_CYCLES) @(posedge o_clk);
         #1;
         o_rst = 1'b1;
         @(posedge i_rst_req);
         @(posedge o_clk);
         #1;
         o_rst = 1'b0;
      end
   end

endmodule

/* verification/fc_decision_props.sv */
// Concurrent checks on reset values, load completion, latency and output hold, bound to the top.
`timescale 1ns/1ps

module fc_decision_props (
   input logic                               i_clk,
   input logic                               i_rst,
   input logic                               i_valid,
   input logic                               i_weight_valid,
   input logic                               i_load_done,
   input logic                               i_dec_done,
   input logic [fc_arith_pkg::CLASS_W-1:0]   i_class
);

   logic [fc_geometry_pkg::PARAM_CNT_W-1:0] strobe_cnt;
   int                                      fail_cnt = 0; // Read from the testbench at the end.

   // Strobes the store should accept, counted up to the full parameter set.
   always @(posedge i_clk) begin
      if (!i_rst) begin
         strobe_cnt <= '0;
      end else if (i_weight_valid && strobe_cnt < fc_geometry_pkg::PARAM_NUM) begin
         strobe_cnt <= strobe_cnt + 1'b1;
      end
   end

   reset_values: assert property (@(posedge i_clk)
      !i_rst |=> (!i_load_done && !i_dec_done && i_class == '0))
      else begin
         fail_cnt++;
         $error("outputs were not cleared by reset");
      end

   load_done_level: assert property (@(posedge i_clk) disable iff (!i_rst)
      i_load_done == (strobe_cnt == fc_geometry_pkg::PARAM_NUM))
      else begin
         fail_cnt++;
         $error("load done flag disagrees with the number of loaded words");
      end

   // Covers both a missing pulse and a pulse with no sample behind it.
   dec_latency: assert property (@(posedge i_clk) disable iff (!i_rst)
      i_dec_done == $past(i_valid, fc_arith_pkg::DEC_LATENCY))
      else begin
         fail_cnt++;
         $error("decision pulse is not exactly seven cycles after its sample");
      end

   class_hold: assert property (@(posedge i_clk) disable iff (!i_rst)
      !i_dec_done |-> $stable(i_class))
      else begin
         fail_cnt++;
         $error("class code changed between decision pulses");
      end

endmodule

bind fc_decision_top fc_decision_props u_props (
   .i_clk          (i_clk),
   .i_rst          (i_rst),
   .i_valid        (i_valid),
   .i_weight_valid (i_weight_valid),
   .i_load_done    (o_load_done),
   .i_dec_done     (o_dec_done),
   .i_class        (o_class)
);

/* verification/fc_decision_tb.sv */
// Self-checking testbench for the classifier output layer; run it as the simulation top.
`timescale 1ns/1ps

module fc_decision_tb;

   localparam logic [31:0] SEED = 32'hea39;
   localparam int SAMPLE_NUM = 200;
   localparam int TEST_NUM = 4 + fc_geometry_pkg::OUTPUT_NUM; // One bias test per neuron.
   localparam int TIMEOUT_CYCLES = TEST_NUM * (fc_geometry_pkg::PARAM_NUM + SAMPLE_NUM
                                               + fc_arith_pkg::DEC_LATENCY);

   logic                                    clk;
   logic                                    rst;
   logic                                    rst_req;
   logic                                    valid;
   logic [fc_geometry_pkg::INPUT_NUM-1:0]
         [fc_arith_pkg::DATA_W-1:0]         data;
   logic                                    weight_valid;
   logic [fc_arith_pkg::WEIGHT_W-1:0]       filter;
   logic                                    load_done;
   logic                                    dec_done;
   logic [fc_arith_pkg::CLASS_W-1:0]        class_code;

   logic signed [fc_arith_pkg::WEIGHT_W-1:0] model_w [fc_geometry_pkg::WEIGHT_NUM];
   logic signed [fc_arith_pkg::WEIGHT_W-1:0] model_b [fc_geometry_pkg::OUTPUT_NUM];
   logic [fc_arith_pkg::CLASS_W-1:0]         exp_q [$];
   logic [fc_arith_pkg::CLASS_W-1:0]         exp_code;
   int                                       error_cnt = 0;
   int                                       check_cnt = 0;
   int                                       test_cnt = 0;
   int                                       total_err;

   tb_clock_gen u_clock_gen (
      .i_rst_req (rst_req),
      .o_clk     (clk),
      .o_rst     (rst)
   );

   fc_decision_top i_dut (
      .i_clk          (clk),
      .i_rst          (rst),
      .i_valid        (valid),
      .i_data         (data),
      .i_weight_valid (weight_valid),
      .i_filter       (filter),
      .o_load_done    (load_done),
      .o_dec_done     (dec_done),
      .o_class        (class_code)
   );

   // Sums are exact in 64 bits; the first maximum wins, as the compare tree promises.
   function automatic logic [fc_arith_pkg::CLASS_W-1:0] expected_code(
      input logic [fc_geometry_pkg::INPUT_NUM-1:0][fc_arith_pkg::DATA_W-1:0] x);
      longint sum;
      longint best;
      int     best_idx;
      best = 0;
      best_idx = 0;
      for (int n = 0; n < fc_geometry_pkg::OUTPUT_NUM; n++) begin
         sum = longint'(model_b[n]);
         for (int f = 0; f < fc_geometry_pkg::INPUT_NUM; f++) begin
            sum += longint'($signed(x[f])) * longint'(model_w[n * fc_geometry_pkg::INPUT_NUM + f]);
         end
         if (n == 0 || sum > best) begin
            best = sum;
            best_idx = n;
         end
      end
      if (best_idx == 0) begin
         return fc_arith_pkg::ZERO_CLASS_CODE;
      end
      return fc_arith_pkg::CLASS_W'(best_idx);
   endfunction

   function automatic logic [fc_geometry_pkg::INPUT_NUM-1:0][fc_arith_pkg::DATA_W-1:0]
      random_features();
      logic [fc_geometry_pkg::INPUT_NUM-1:0][fc_arith_pkg::DATA_W-1:0] x;
      for (int f = 0; f < fc_geometry_pkg::INPUT_NUM; f++) begin
         x[f] = fc_arith_pkg::DATA_W'($urandom);
      end
      return x;
   endfunction

   task automatic clear_model();
      for (int i = 0; i < fc_geometry_pkg::WEIGHT_NUM; i++) begin
         model_w[i] = '0;
      end
      for (int n = 0; n < fc_geometry_pkg::OUTPUT_NUM; n++) begin
         model_b[n] = '0;
      end
   endtask

   task automatic drive_idle();
      @(posedge clk);
      #1;
      valid = 1'b0;
      weight_valid = 1'b0;
   endtask

   task automatic send_sample(
      input logic [fc_geometry_pkg::INPUT_NUM-1:0][fc_arith_pkg::DATA_W-1:0] x);
      @(posedge clk);
      #1;
      valid = 1'b1;
      data = x;
      exp_q.push_back(expected_code(x));
   endtask

   // Sends the model's parameters in load order, weights first.
   task automatic stream_params();
      for (int i = 0; i < fc_geometry_pkg::PARAM_NUM; i++) begin
         @(posedge clk);
         #1;
         weight_valid = 1'b1;
         if (i < fc_geometry_pkg::WEIGHT_NUM) begin
            filter = model_w[i];
         end else begin
            filter = model_b[i - fc_geometry_pkg::WEIGHT_NUM];
         end
      end
      drive_idle();
   endtask

   task automatic send_extra_strobes(input int count);
      for (int i = 0; i < count; i++) begin
         @(posedge clk);
         #1;
         weight_valid = 1'b1;
         filter = fc_arith_pkg::WEIGHT_W'($urandom); // The store must ignore these.
      end
   endtask

   task automatic finish_test(input string name);
      drive_idle();
      while (exp_q.size() != 0) begin
         @(posedge clk);
      end
      test_cnt++;
      $display("test %-14s done, %0d results checked so far, %0d errors",
               name, check_cnt, error_cnt + i_dut.u_props.fail_cnt);
   endtask

   task automatic restart_dut();
      rst_req = 1'b1;
      while (rst !== 1'b0) begin
         @(posedge clk);
      end
      rst_req = 1'b0;
      while (rst !== 1'b1) begin
         @(posedge clk);
      end
      clear_model();
   endtask

   always @(negedge clk) begin
      if (rst === 1'b1 && dec_done === 1'b1) begin
         assert (exp_q.size() != 0) else begin
            $display("decision pulse arrived with no sample waiting for it");
            error_cnt++;
         end
         if (exp_q.size() != 0) begin
            exp_code = exp_q.pop_front();
            check_cnt++;
            assert (class_code === exp_code) else begin
               $display("error: o_class = 0x%h, expected 0x%h", class_code, exp_code);
               error_cnt++;
            end
         end
      end
   end

   initial begin
      repeat (TIMEOUT_CYCLES) @(posedge clk);
      $display("timeout: the tests did not finish within %0d clock cycles", TIMEOUT_CYCLES);
      $display(">>> FAIL");
      $finish;
   end

   initial begin
      void'($urandom(SEED));
      valid = 1'b0;
      data = '0;
      weight_valid = 1'b0;
      filter = '0;
      rst_req = 1'b0;
      clear_model();
      while (rst !== 1'b1) begin
         @(posedge clk);
      end

      // Nothing loaded yet, so all sums are zero and class 0 wins the tie.
      for (int i = 0; i < 3; i++) begin
         send_sample(random_features());
      end
      finish_test("early_sample");

      for (int i = 0; i < fc_geometry_pkg::WEIGHT_NUM; i++) begin
         model_w[i] = fc_arith_pkg::WEIGHT_W'($urandom);
      end
      for (int n = 0; n < fc_geometry_pkg::OUTPUT_NUM; n++) begin
         model_b[n] = fc_arith_pkg::WEIGHT_W'($urandom);
      end
      stream_params();
      send_extra_strobes(8);
      finish_test("load");

      for (int i = 0; i < SAMPLE_NUM; i++) begin
         if ($urandom_range(3, 0) == 0) begin
            drive_idle(); // Some gaps, mostly back-to-back samples.
         end
         send_sample(random_features());
      end
      finish_test("random_class");

      restart_dut();
      for (int n = 0; n < fc_geometry_pkg::OUTPUT_NUM; n++) begin
         model_b[n] = 8'sd37;
      end
      stream_params();
      for (int i = 0; i < 3; i++) begin
         send_sample(random_features());
      end
      finish_test("bias_tie");

      for (int k = 0; k < fc_geometry_pkg::OUTPUT_NUM; k++) begin
         restart_dut();
         for (int n = 0; n < fc_geometry_pkg::OUTPUT_NUM; n++) begin
            model_b[n] = fc_arith_pkg::WEIGHT_W'(int'($urandom_range(227, 0)) - 128);
         end
         model_b[k] = fc_arith_pkg::WEIGHT_W'($urandom_range(127, 100));
         stream_params();
         send_sample(random_features());
         send_sample(random_features());
         finish_test($sformatf("bias_max_%0d", k));
      end

      total_err = error_cnt + i_dut.u_props.fail_cnt;
      $display("tests run %0d of %0d, results checked %0d, errors %0d",
               test_cnt, TEST_NUM, check_cnt, total_err);
      if (total_err == 0) begin
         $display(">>> PASS");
      end else begin
         $display(">>> FAIL");
      end
      $finish;
   end

endmodule

/* project.f */
design/fc_geometry_pkg.sv
design/fc_arith_pkg.sv
design/fc_param_store.sv
design/fc_dot_product.sv
design/fc_argmax.sv
design/fc_decision_top.sv
verification/tb_clock_gen.sv
verification/fc_decision_props.sv
verification/fc_decision_tb.sv

/* Makefile */
TOP := fc_decision_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check sim.log for the pass line"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal -j 0 --top-module $(TOP) \
		-f project.f -Mdir obj_dir -o sim
	./obj_dir/sim +verilator+error+limit+1000 | tee sim.log
	@grep -q '^>>> PASS$$' sim.log

clean:
	rm -rf obj_dir sim.log
